// ==== mips_pkg.sv ====
// shared widths and encodings for the MIPS32 subset core; the opcode and funct values follow the standard MIPS32 encoding
package mips_pkg;

  typedef logic [31:0] word_t;      // data word, instruction word or byte address
  typedef logic [4:0]  reg_addr_t;  // register number
  typedef logic [15:0] imm_t;       // I-type immediate field
  typedef logic [25:0] jtarget_t;   // J-type target field
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [3:0]  alu_ctrl_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [1:0]  dst_sel_t;

  // primary opcodes
  localparam opcode_t op_rtype = 6'h00;
  localparam opcode_t op_j     = 6'h02;
  localparam opcode_t op_jal   = 6'h03;
  localparam opcode_t op_beq   = 6'h04;
  localparam opcode_t op_addi  = 6'h08;
  localparam opcode_t op_lw    = 6'h23;
  localparam opcode_t op_sw    = 6'h2b;

  // funct codes for R-type
  localparam funct_t fn_add = 6'h20;
  localparam funct_t fn_sub = 6'h22;
  localparam funct_t fn_and = 6'h24;
  localparam funct_t fn_or  = 6'h25;
  localparam funct_t fn_slt = 6'h2a;

  // ALU operations
  localparam alu_ctrl_t alu_and = 4'b0000;
  localparam alu_ctrl_t alu_or  = 4'b0001;
  localparam alu_ctrl_t alu_add = 4'b0010;
  localparam alu_ctrl_t alu_sub = 4'b0110;
  localparam alu_ctrl_t alu_slt = 4'b0111;  // signed compare

  // write-back source
  localparam wb_sel_t wb_alu  = 2'd0;
  localparam wb_sel_t wb_mem  = 2'd1;
  localparam wb_sel_t wb_link = 2'd2;  // pc + 4 for jal

  // destination register select
  localparam dst_sel_t dst_rt = 2'd0;
  localparam dst_sel_t dst_rd = 2'd1;
  localparam dst_sel_t dst_ra = 2'd2;

  localparam reg_addr_t link_reg = 5'd31;

endpackage

// ==== decode_if.sv ====
// decoded instruction fields and control levels; all signals are combinational within one cycle
interface decode_if;
  import mips_pkg::*;

  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      immediate;
  jtarget_t  jump_target;

  alu_ctrl_t alu_ctrl;
  logic      alu_src;    // 1 selects the sign-extended immediate
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  logic      branch;     // beq
  logic      jump;       // j and jal
  wb_sel_t   wb_sel;
  dst_sel_t  dst_sel;

  // control_unit side
  modport control (
    output rt, rd, immediate, jump_target,
    output alu_ctrl, alu_src, mem_read, mem_write,
    output reg_write, branch, jump, wb_sel, dst_sel
  );

  // execute_unit side
  modport execute (
    input rt, rd, immediate, jump_target,
    input alu_ctrl, alu_src, mem_read, mem_write,
    input reg_write, branch, jump, wb_sel, dst_sel
  );

endinterface

// ==== instr_fetch.sv ====
// imem_words must be a power of two (at least 2); load_addr is a word index, loads only while run is low
module instr_fetch #(
  parameter int imem_words = 256
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            run,
  input  logic            load_we,
  input  mips_pkg::word_t load_addr,
  input  mips_pkg::word_t load_data,
  input  mips_pkg::word_t next_pc,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t instr
);
  import mips_pkg::*;

  localparam int iaw = $clog2(imem_words);

  word_t imem [imem_words];

  logic [iaw-1:0] fetch_idx;
  logic [iaw-1:0] load_idx;

  assign fetch_idx = pc[iaw+1:2];       // word address, upper bits wrap
  assign load_idx  = load_addr[iaw-1:0];

  // program counter holds while the core is idle
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  // loader port is the only writer
  always_ff @(posedge clock) begin
    if (load_we && !run) begin
      imem[load_idx] <= load_data;
    end
  end

  assign instr = imem[fetch_idx];  // asynchronous read

endmodule

// ==== control_unit.sv ====
// purely combinational decode; unknown opcode or funct acts as a no-op and flags illegal_opcode while run is high
module control_unit (
  input  logic                run,
  input  mips_pkg::word_t     instr,
  output mips_pkg::reg_addr_t rs,
  output mips_pkg::reg_addr_t rt,
  decode_if.control           dec,
  output logic                illegal_opcode
);
  import mips_pkg::*;

  opcode_t opcode;
  funct_t  funct;
  logic    illegal;

  // instruction fields
  assign opcode          = instr[31:26];
  assign rs              = instr[25:21];
  assign rt              = instr[20:16];
  assign funct           = instr[5:0];
  assign dec.rt          = instr[20:16];
  assign dec.rd          = instr[15:11];
  assign dec.immediate   = instr[15:0];
  assign dec.jump_target = instr[25:0];

  always_comb begin
    // defaults describe a no-op
    dec.alu_ctrl  = alu_add;
    dec.alu_src   = 1'b0;
    dec.mem_read  = 1'b0;
    dec.mem_write = 1'b0;
    dec.reg_write = 1'b0;
    dec.branch    = 1'b0;
    dec.jump      = 1'b0;
    dec.wb_sel    = wb_alu;
    dec.dst_sel   = dst_rt;
    illegal       = 1'b0;

    case (opcode)
      op_rtype: begin
        dec.reg_write = 1'b1;
        dec.dst_sel   = dst_rd;
        case (funct)  // ALU op comes from funct
          fn_add:  dec.alu_ctrl = alu_add;
          fn_sub:  dec.alu_ctrl = alu_sub;
          fn_and:  dec.alu_ctrl = alu_and;
          fn_or:   dec.alu_ctrl = alu_or;
          fn_slt:  dec.alu_ctrl = alu_slt;
          default: illegal = 1'b1;
        endcase
      end
      op_addi: begin
        dec.reg_write = 1'b1;
        dec.alu_src   = 1'b1;
      end
      op_lw: begin
        dec.reg_write = 1'b1;
        dec.alu_src   = 1'b1;
        dec.mem_read  = 1'b1;
        dec.wb_sel    = wb_mem;
      end
      op_sw: begin
        dec.alu_src   = 1'b1;  // address is base + offset
        dec.mem_write = 1'b1;
      end
      op_beq: begin
        dec.alu_ctrl = alu_sub;  // zero result means equal
        dec.branch   = 1'b1;
      end
      op_j: begin
        dec.jump = 1'b1;
      end
      op_jal: begin
        dec.jump      = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = wb_link;
        dec.dst_sel   = dst_ra;
      end
      default: illegal = 1'b1;
    endcase

    // illegal instructions must not change architectural state
    if (illegal) begin
      dec.reg_write = 1'b0;
      dec.mem_write = 1'b0;
      dec.mem_read  = 1'b0;
      dec.branch    = 1'b0;
      dec.jump      = 1'b0;
    end
  end

  assign illegal_opcode = run && illegal;

endmodule

// ==== reg_file.sv ====
// 32 x 32 registers without reset; a read of the register written in the same cycle returns the old value
module reg_file (
  input  logic                clock,
  input  mips_pkg::reg_addr_t rs,
  input  mips_pkg::reg_addr_t rt,
  output mips_pkg::word_t     rs_data,
  output mips_pkg::word_t     rt_data,
  input  logic                wr_en,
  input  mips_pkg::reg_addr_t wr_addr,
  input  mips_pkg::word_t     wr_data
);
  import mips_pkg::*;

  word_t regs [32];

  // register zero is never written
  always_ff @(posedge clock) begin
    if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // asynchronous reads, $zero forced here
  assign rs_data = (rs == '0) ? '0 : regs[rs];
  assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== execute_unit.sv ====
// combinational datapath with word-only data memory; dmem_words must be a power of two (at least 2)
module execute_unit #(
  parameter int dmem_words = 256
) (
  input  logic                clock,
  input  logic                run,
  input  mips_pkg::word_t     pc,
  input  mips_pkg::word_t     rs_data,
  input  mips_pkg::word_t     rt_data,
  decode_if.execute           dec,
  output logic                wr_en,
  output mips_pkg::reg_addr_t wr_addr,
  output mips_pkg::word_t     wr_data,
  output mips_pkg::word_t     next_pc,
  output logic                dmem_we,
  output mips_pkg::word_t     dmem_addr,
  output mips_pkg::word_t     dmem_wdata
);
  import mips_pkg::*;

  localparam int daw = $clog2(dmem_words);

  word_t dmem [dmem_words];

  word_t          imm_ext;
  word_t          alu_b;
  word_t          alu_result;
  logic           alu_zero;
  word_t          load_data;
  word_t          pc_plus4;
  logic [daw-1:0] dmem_idx;

  assign imm_ext = {{16{dec.immediate[15]}}, dec.immediate};
  assign alu_b   = dec.alu_src ? imm_ext : rt_data;

  // ALU
  always_comb begin
    case (dec.alu_ctrl)
      alu_add: alu_result = rs_data + alu_b;
      alu_sub: alu_result = rs_data - alu_b;
      alu_and: alu_result = rs_data & alu_b;
      alu_or:  alu_result = rs_data | alu_b;
      alu_slt: alu_result = {31'b0, $signed(rs_data) < $signed(alu_b)};
      default: alu_result = '0;
    endcase
  end

  assign alu_zero = (alu_result == '0);

  // data memory, word addressed by the ALU result
  assign dmem_idx   = alu_result[daw+1:2];
  assign dmem_we    = run && dec.mem_write;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rt_data;

  always_ff @(posedge clock) begin
    if (dmem_we) begin
      dmem[dmem_idx] <= rt_data;
    end
  end

  assign load_data = dec.mem_read ? dmem[dmem_idx] : '0;  // combinational load

  // write-back
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (dec.wb_sel)
      wb_mem:  wr_data = load_data;
      wb_link: wr_data = pc_plus4;
      default: wr_data = alu_result;
    endcase
  end

  always_comb begin
    case (dec.dst_sel)
      dst_rd:  wr_addr = dec.rd;
      dst_ra:  wr_addr = link_reg;
      default: wr_addr = dec.rt;
    endcase
  end

  assign wr_en = run && dec.reg_write;  // $zero writes are dropped in reg_file

  // next pc
  always_comb begin
    if (dec.jump) begin
      next_pc = {pc_plus4[31:28], dec.jump_target, 2'b00};
    end else if (dec.branch && alu_zero) begin
      next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
    end else begin
      next_pc = pc_plus4;
    end
  end

endmodule

// ==== cpu.sv ====
// single-cycle core, one instruction per clock while run is high; load the program with run low
module cpu #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                run,
  input  logic                load_we,
  input  mips_pkg::word_t     load_addr,
  input  mips_pkg::word_t     load_data,
  output logic                retire_valid,
  output mips_pkg::word_t     retire_pc,
  output logic                wb_en,
  output mips_pkg::reg_addr_t wb_addr,
  output mips_pkg::word_t     wb_data,
  output logic                dmem_we,
  output mips_pkg::word_t     dmem_addr,
  output mips_pkg::word_t     dmem_wdata,
  output logic                illegal_opcode
);
  import mips_pkg::*;

  word_t     pc;
  word_t     instr;
  word_t     next_pc;
  reg_addr_t rs;
  reg_addr_t rt;
  word_t     rs_data;
  word_t     rt_data;
  logic      wr_en;
  reg_addr_t wr_addr;
  word_t     wr_data;

  decode_if dec_bus ();

  instr_fetch #(.imem_words(imem_words)) fetch0 (
    .clock     (clock),
    .reset     (reset),
    .run       (run),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .next_pc   (next_pc),
    .pc        (pc),
    .instr     (instr)
  );

  control_unit control0 (
    .run            (run),
    .instr          (instr),
    .rs             (rs),
    .rt             (rt),
    .dec            (dec_bus.control),
    .illegal_opcode (illegal_opcode)
  );

  reg_file regs0 (
    .clock   (clock),
    .rs      (rs),
    .rt      (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  execute_unit #(.dmem_words(dmem_words)) exec0 (
    .clock      (clock),
    .run        (run),
    .pc         (pc),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .dec        (dec_bus.execute),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .next_pc    (next_pc),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata)
  );

  // retire trace, valid in the cycle before the retiring edge
  assign retire_valid = run;
  assign retire_pc    = pc;
  assign wb_en        = wr_en;
  assign wb_addr      = wr_addr;
  assign wb_data      = wr_data;

endmodule

// ==== cpu_assert.sv ====
// bound into cpu; the expected trace is read from the reference model in tb_cpu
module cpu_assert (
  input logic                clock,
  input logic                retire_valid,
  input mips_pkg::word_t     retire_pc,
  input logic                wb_en,
  input mips_pkg::reg_addr_t wb_addr,
  input mips_pkg::word_t     wb_data,
  input logic                dmem_we,
  input mips_pkg::word_t     dmem_addr,
  input mips_pkg::word_t     dmem_wdata,
  input logic                illegal_opcode
);
  timeunit 1ns;
  timeprecision 100ps;
  import mips_pkg::*;

  logic        fail_seen = 1'b0;  // details of the first mismatch
  string       fail_name;
  logic [95:0] fail_exp;
  logic [95:0] fail_act;

  task automatic note_fail(input string name, input logic [95:0] exp_v,
                           input logic [95:0] act_v);
    $error("%s check failed", name);
    if (!fail_seen) begin
      fail_seen = 1'b1;
      fail_name = name;
      fail_exp  = exp_v;
      fail_act  = act_v;
    end
  endtask

  // no trace activity in reset or while loading
  idle_quiet: assert property (@(posedge clock)
      !retire_valid |-> !wb_en && !dmem_we && !illegal_opcode)
    else note_fail("idle_quiet", '0, $sampled({wb_en, dmem_we, illegal_opcode}));

  start_pc: assert property (@(posedge clock) $rose(retire_valid) |-> retire_pc == '0)
    else note_fail("start_pc", '0, $sampled(retire_pc));

  retire_order: assert property (@(posedge clock)
      retire_valid == tb_cpu.exp_valid && (!retire_valid || retire_pc == tb_cpu.exp_pc))
    else note_fail("retire_pc", {tb_cpu.exp_valid, tb_cpu.exp_pc},
                   $sampled({retire_valid, retire_pc}));

  writeback: assert property (@(posedge clock) retire_valid |->
      wb_en == tb_cpu.exp_wb_en &&
      (!wb_en || (wb_addr == tb_cpu.exp_wb_addr && wb_data == tb_cpu.exp_wb_data)))
    else note_fail("writeback", {tb_cpu.exp_wb_en, tb_cpu.exp_wb_addr, tb_cpu.exp_wb_data},
                   $sampled({wb_en, wb_addr, wb_data}));

  dmem_access: assert property (@(posedge clock) retire_valid |->
      dmem_we == tb_cpu.exp_dmem_we && (!dmem_we ||
      (dmem_addr == tb_cpu.exp_dmem_addr && dmem_wdata == tb_cpu.exp_dmem_wdata)))
    else note_fail("dmem_access",
                   {tb_cpu.exp_dmem_we, tb_cpu.exp_dmem_addr, tb_cpu.exp_dmem_wdata},
                   $sampled({dmem_we, dmem_addr, dmem_wdata}));

  // an illegal instruction changes no state
  illegal_flag: assert property (@(posedge clock) retire_valid |->
      illegal_opcode == tb_cpu.exp_illegal && (!illegal_opcode || (!wb_en && !dmem_we)))
    else note_fail("illegal_opcode", {tb_cpu.exp_illegal, 2'b00},
                   $sampled({illegal_opcode, wb_en, dmem_we}));

endmodule

// ==== tb_cpu.sv ====
// random program with forward branches only, registers 1 to 15 set before use; 256-word memories
module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;
  import mips_pkg::*;

  localparam int reset_cycles = 8;
  localparam int mem_depth    = 256;

  logic      clock, reset, run, load_we;
  word_t     load_addr, load_data;
  logic      retire_valid, wb_en, dmem_we, illegal_opcode;
  word_t     retire_pc, wb_data, dmem_addr, dmem_wdata;
  reg_addr_t wb_addr;

  // reference model state and the trace it predicts
  word_t       prog [$];
  word_t       m_regs [32];
  word_t       m_mem [mem_depth];
  word_t       m_pc;
  logic [31:0] lfsr;
  int          cycles = 0;
  logic        exp_valid, exp_wb_en, exp_dmem_we, exp_illegal;
  word_t       exp_pc, exp_wb_data, exp_dmem_addr, exp_dmem_wdata;
  reg_addr_t   exp_wb_addr;

  cpu #(.imem_words(mem_depth), .dmem_words(mem_depth)) dut0 (.*);

  bind cpu cpu_assert chk0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    repeat (n) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;  // galois step
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(rand_bits(4));
  endfunction

  function automatic word_t rand_itype(input opcode_t op);
    return {op, rand_reg(), rand_reg(), imm_t'(rand_bits(16))};
  endfunction

  task automatic write_back(input reg_addr_t addr, input word_t data);
    exp_wb_en   = 1'b1;
    exp_wb_addr = addr;
    exp_wb_data = data;
    if (addr != '0) begin
      m_regs[addr] = data;  // $zero stays zero
    end
  endtask

  // predicts the instruction at m_pc, then retires it in the model
  task automatic model_step();
    word_t ins, a, b, imm, addr, pc4, nxt;
    ins  = prog[m_pc >> 2];
    a    = m_regs[ins[25:21]];
    b    = m_regs[ins[20:16]];
    imm  = {{16{ins[15]}}, ins[15:0]};
    addr = a + imm;
    pc4  = m_pc + 32'd4;
    nxt  = pc4;
    exp_pc      = m_pc;
    exp_wb_en   = 1'b0;
    exp_dmem_we = 1'b0;
    exp_illegal = 1'b0;
    case (ins[31:26])
      op_rtype: begin
        case (ins[5:0])
          fn_add:  write_back(ins[15:11], a + b);
          fn_sub:  write_back(ins[15:11], a - b);
          fn_and:  write_back(ins[15:11], a & b);
          fn_or:   write_back(ins[15:11], a | b);
          fn_slt:  write_back(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          default: exp_illegal = 1'b1;
        endcase
      end
      op_addi: write_back(ins[20:16], addr);
      op_lw:   write_back(ins[20:16], m_mem[(addr >> 2) % mem_depth]);
      op_sw: begin
        exp_dmem_we    = 1'b1;
        exp_dmem_addr  = addr;
        exp_dmem_wdata = b;
        m_mem[(addr >> 2) % mem_depth] = b;
      end
      op_beq: if (a == b) nxt = pc4 + (imm << 2);
      op_j:   nxt = {pc4[31:28], ins[25:0], 2'b00};
      op_jal: begin
        write_back(link_reg, pc4);
        nxt = {pc4[31:28], ins[25:0], 2'b00};
      end
      default: exp_illegal = 1'b1;
    endcase
    m_pc = nxt;
  endtask

  task automatic fail_run();
    $display("[ERROR] %s: expected %h, actual %h", dut0.chk0.fail_name,
             dut0.chk0.fail_exp, dut0.chk0.fail_act);
    $display("Finished with errors");
    $fatal(1, "reference model mismatch");
  endtask

  // stop at the first recorded mismatch, or when the run takes too long
  always @(negedge clock) begin
    cycles = cycles + 1;
    if (dut0.chk0.fail_seen) begin
      fail_run();
    end else if (cycles > reset_cycles + 3 * prog.size() + 50) begin
      $display("timeout: program did not finish within %0d cycles", cycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  initial begin
    funct_t    fns [5];
    reg_addr_t base;
    imm_t      off;
    reset     = 1'b1;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    exp_valid = 1'b0;
    lfsr      = 32'he50;
    m_pc      = '0;
    foreach (m_regs[i]) m_regs[i] = '0;
    fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};

    for (int r = 1; r < 16; r++) begin
      prog.push_back({op_addi, 5'd0, 5'(r), imm_t'(rand_bits(16))});
    end
    for (int blk = 0; blk < 2; blk++) begin
      base = rand_reg();
      off  = imm_t'(rand_bits(16));
      prog.push_back(rand_itype(op_addi));
      foreach (fns[k]) begin
        prog.push_back({op_rtype, rand_reg(), rand_reg(), rand_reg(), 5'd0, fns[k]});
      end
      prog.push_back({op_sw, base, rand_reg(), off});  // store, then load it back
      prog.push_back({op_lw, base, rand_reg(), off});
      prog.push_back({op_beq, base, base, 16'd1});  // always taken
      prog.push_back(rand_itype(op_addi));
      prog.push_back({op_addi, 5'd0, 5'd1, 16'd1});  // $1 = 1 keeps the next beq from branching
      prog.push_back({op_beq, 5'd0, 5'd1, 16'd1});  // never taken
      prog.push_back(rand_itype(op_addi));
      prog.push_back({op_j, jtarget_t'(prog.size() + 2)});
      prog.push_back(rand_itype(op_addi));  // skipped
      prog.push_back({op_jal, jtarget_t'(prog.size() + 2)});
      prog.push_back(rand_itype(op_addi));
      prog.push_back({op_addi, rand_reg(), 5'd0, off});  // write to $zero is dropped
      prog.push_back({op_rtype, 5'd0, 5'd0, rand_reg(), 5'd0, fn_add});
      prog.push_back({6'h3f, jtarget_t'(rand_bits(26))});  // undefined opcode
    end

    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clock);
      load_we   = 1'b1;
      load_addr = i;
      load_data = prog[i];
    end
    @(negedge clock);
    load_we = 1'b0;

    while (m_pc < 4 * prog.size()) begin
      @(negedge clock);
      run       = 1'b1;
      exp_valid = 1'b1;
      model_step();
    end
    @(negedge clock);
    run       = 1'b0;
    exp_valid = 1'b0;
    repeat (2) @(negedge clock);
    if (dut0.chk0.fail_seen) begin
      fail_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
mips_pkg.sv
decode_if.sv
instr_fetch.sv
control_unit.sv
reg_file.sv
execute_unit.sv
cpu.sv
cpu_assert.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: mips_cpu

sources:
  - mips_pkg.sv
  - decode_if.sv
  - instr_fetch.sv
  - control_unit.sv
  - reg_file.sv
  - execute_unit.sv
  - cpu.sv
  - target: test
    files:
      - cpu_assert.sv
      - tb_cpu.sv
